//--- Makefile
# Verilator flow for the TCDM interconnect
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_tcdm_interconnect
FILELIST  ?= tcdm_interconnect.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/tcdm_amo_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_amo_bank (
  input  wire logic                                clk_i,
  input  wire logic                                arst_n_i,
  input  wire logic                                valid_i,
  input  wire logic [$clog2(`TCDM_BANK_WORDS)-1:0] word_i,
  input  wire logic                                we_i,
  input  wire logic [`TCDM_DATA_WIDTH-1:0]         wdata_i,
  input  wire logic [`TCDM_BE_WIDTH-1:0]           be_i,
  input  tcdm_pkg::amo_op_e                        amo_i,
  output logic [`TCDM_DATA_WIDTH-1:0]              r_rdata_o
);

  localparam int unsigned DataWidth = `TCDM_DATA_WIDTH;
  localparam int unsigned BeWidth   = `TCDM_BE_WIDTH;
  localparam int unsigned BankWords = `TCDM_BANK_WORDS;

  logic [DataWidth-1:0] mem_q [BankWords];
  logic [DataWidth-1:0] old_word;
  logic [DataWidth-1:0] amo_result;
  logic [DataWidth-1:0] new_word;
  logic                 is_amo;
  logic                 write_en;

  assign old_word = mem_q[word_i];
  assign is_amo   = (amo_i != tcdm_pkg::AMO_NONE);

  // Atomic ALU on the old word and the request operand
  always_comb begin
    case (amo_i)
      tcdm_pkg::AMO_SWAP: amo_result = wdata_i;
      tcdm_pkg::AMO_ADD:  amo_result = old_word + wdata_i;
      tcdm_pkg::AMO_AND:  amo_result = old_word & wdata_i;
      tcdm_pkg::AMO_OR:   amo_result = old_word | wdata_i;
      tcdm_pkg::AMO_XOR:  amo_result = old_word ^ wdata_i;
      tcdm_pkg::AMO_MAX: begin
        amo_result = ($signed(old_word) > $signed(wdata_i)) ? old_word : wdata_i;
      end
      tcdm_pkg::AMO_MAXU: amo_result = (old_word > wdata_i) ? old_word : wdata_i;
      tcdm_pkg::AMO_MIN: begin
        amo_result = ($signed(old_word) < $signed(wdata_i)) ? old_word : wdata_i;
      end
      tcdm_pkg::AMO_MINU: amo_result = (old_word < wdata_i) ? old_word : wdata_i;
      default:            amo_result = old_word;
    endcase
  end

  // Atomics take the full word, plain writes merge by byte
  always_comb begin
    new_word = old_word;
    if (is_amo) begin
      new_word = amo_result;
    end else begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          new_word[8*b +: 8] = wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign write_en = valid_i && (we_i || is_amo);

  always_ff @(posedge clk_i) begin
    if (write_en) begin
      mem_q[word_i] <= new_word;
    end
  end

  // Old value leaves on the same edge that stores the new one
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_rdata_o <= '0;
    end else if (valid_i) begin
      r_rdata_o <= old_word;
    end
  end

endmodule

`default_nettype wire

//--- source/tcdm_bank_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_bank_arbiter #(
  parameter int unsigned NumIn = `TCDM_NB_MASTERS
) (
  input  wire logic                                              clk_i,
  input  wire logic                                              arst_n_i,
  input  wire logic [NumIn-1:0]                                  req_i,
  input  wire logic [NumIn-1:0][$clog2(`TCDM_BANK_WORDS)-1:0]    word_i,
  input  wire logic [NumIn-1:0]                                  we_i,
  input  wire logic [NumIn-1:0][`TCDM_DATA_WIDTH-1:0]            wdata_i,
  input  wire logic [NumIn-1:0][`TCDM_BE_WIDTH-1:0]              be_i,
  input  tcdm_pkg::amo_op_e [NumIn-1:0]                          amo_i,
  output logic [NumIn-1:0]                                       gnt_o,
  output logic                                                   valid_o,
  output logic [$clog2(`TCDM_BANK_WORDS)-1:0]                    word_o,
  output logic                                                   we_o,
  output logic [`TCDM_DATA_WIDTH-1:0]                            wdata_o,
  output logic [`TCDM_BE_WIDTH-1:0]                              be_o,
  output tcdm_pkg::amo_op_e                                      amo_o
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] win;
  logic                found;

  // Search from the pointer upwards and wrap around
  always_comb begin : rr_pick
    int unsigned idx;
    found = 1'b0;
    win   = ptr_q;
    gnt_o = '0;
    for (int unsigned i = 0; i < NumIn; i++) begin
      idx = (32'(ptr_q) + i) % NumIn;
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        win        = IdxWidth'(idx);
        gnt_o[idx] = 1'b1;
      end
    end
  end

  assign valid_o = found;

  // Winner's payload goes straight to the bank
  assign word_o  = word_i[win];
  assign we_o    = we_i[win];
  assign wdata_o = wdata_i[win];
  assign be_o    = be_i[win];
  assign amo_o   = amo_i[win];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= (32'(win) == NumIn - 1) ? '0 : win + 1'b1;
    end
  end

  gnt_onehot_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_o)
  ) else $error("bank granted more than one master: %b", gnt_o);

  gnt_to_req_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (gnt_o & ~req_i) == '0
  ) else $error("grant %b without request %b", gnt_o, req_i);

endmodule

`default_nettype wire

//--- source/tcdm_consts.svh
`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// Requesters that share the scratchpad
`define TCDM_NB_MASTERS 4

// Word-interleaved banks, must stay a power of two
`define TCDM_NB_BANKS 4

// Depth of each bank in words
`define TCDM_BANK_WORDS 64

// Data word width in bits
`define TCDM_DATA_WIDTH 32

// Byte address width seen by the masters
`define TCDM_ADDR_WIDTH 32

// One enable per data byte
`define TCDM_BE_WIDTH 4

// Atomic code, bit 5 marks an atomic and bits 4..0 carry funct5
`define TCDM_ATOP_WIDTH 6

`endif

//--- source/tcdm_interconnect.sv
`timescale 1ns/100ps
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_interconnect (
  input  wire logic                                              clk_i,
  input  wire logic                                              arst_n_i,
  input  wire logic [`TCDM_NB_MASTERS-1:0]                       req_i,
  input  wire logic [`TCDM_NB_MASTERS-1:0][`TCDM_ADDR_WIDTH-1:0] add_i,
  input  wire logic [`TCDM_NB_MASTERS-1:0]                       we_i,
  input  wire logic [`TCDM_NB_MASTERS-1:0][`TCDM_DATA_WIDTH-1:0] wdata_i,
  input  wire logic [`TCDM_NB_MASTERS-1:0][`TCDM_BE_WIDTH-1:0]   be_i,
  input  wire logic [`TCDM_NB_MASTERS-1:0][`TCDM_ATOP_WIDTH-1:0] atop_i,
  output logic [`TCDM_NB_MASTERS-1:0]                            gnt_o,
  output logic [`TCDM_NB_MASTERS-1:0]                            r_valid_o,
  output logic [`TCDM_NB_MASTERS-1:0][`TCDM_DATA_WIDTH-1:0]      r_rdata_o
);

  localparam int unsigned NbMasters = `TCDM_NB_MASTERS;
  localparam int unsigned NbBanks   = `TCDM_NB_BANKS;
  localparam int unsigned WordWidth = $clog2(`TCDM_BANK_WORDS);

  // Master side, indexed [master][bank]
  logic [NbMasters-1:0][NbBanks-1:0]          m_bank_req;
  logic [NbMasters-1:0][NbBanks-1:0]          m_bank_gnt;
  logic [NbMasters-1:0][WordWidth-1:0]        m_word;
  logic [NbMasters-1:0]                       m_we;
  logic [NbMasters-1:0][`TCDM_DATA_WIDTH-1:0] m_wdata;
  logic [NbMasters-1:0][`TCDM_BE_WIDTH-1:0]   m_be;
  tcdm_pkg::amo_op_e [NbMasters-1:0]          m_amo;

  // Bank side, indexed [bank][master]
  logic [NbBanks-1:0][NbMasters-1:0]          b_req;
  logic [NbBanks-1:0][NbMasters-1:0]          b_gnt;
  logic [NbBanks-1:0]                         b_valid;
  logic [NbBanks-1:0][WordWidth-1:0]          b_word;
  logic [NbBanks-1:0]                         b_we;
  logic [NbBanks-1:0][`TCDM_DATA_WIDTH-1:0]   b_wdata;
  logic [NbBanks-1:0][`TCDM_BE_WIDTH-1:0]     b_be;
  tcdm_pkg::amo_op_e [NbBanks-1:0]            b_amo;
  logic [NbBanks-1:0][`TCDM_DATA_WIDTH-1:0]   b_rdata;

  for (genvar m = 0; m < NbMasters; m++) begin : gen_master
    tcdm_master_port u_master_port (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .req_i        (req_i[m]),
      .add_i        (add_i[m]),
      .we_i         (we_i[m]),
      .wdata_i      (wdata_i[m]),
      .be_i         (be_i[m]),
      .atop_i       (atop_i[m]),
      .gnt_o        (gnt_o[m]),
      .r_valid_o    (r_valid_o[m]),
      .r_rdata_o    (r_rdata_o[m]),
      .bank_req_o   (m_bank_req[m]),
      .word_o       (m_word[m]),
      .bank_we_o    (m_we[m]),
      .bank_wdata_o (m_wdata[m]),
      .bank_be_o    (m_be[m]),
      .amo_o        (m_amo[m]),
      .bank_gnt_i   (m_bank_gnt[m]),
      .bank_rdata_i (b_rdata)
    );

    // Swap request and grant vectors between master and bank order
    for (genvar b = 0; b < NbBanks; b++) begin : gen_xpose
      assign b_req[b][m]      = m_bank_req[m][b];
      assign m_bank_gnt[m][b] = b_gnt[b][m];
    end
  end

  for (genvar b = 0; b < NbBanks; b++) begin : gen_bank
    tcdm_bank_arbiter #(
      .NumIn (NbMasters)
    ) u_bank_arbiter (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (b_req[b]),
      .word_i   (m_word),
      .we_i     (m_we),
      .wdata_i  (m_wdata),
      .be_i     (m_be),
      .amo_i    (m_amo),
      .gnt_o    (b_gnt[b]),
      .valid_o  (b_valid[b]),
      .word_o   (b_word[b]),
      .we_o     (b_we[b]),
      .wdata_o  (b_wdata[b]),
      .be_o     (b_be[b]),
      .amo_o    (b_amo[b])
    );

    tcdm_amo_bank u_amo_bank (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .valid_i   (b_valid[b]),
      .word_i    (b_word[b]),
      .we_i      (b_we[b]),
      .wdata_i   (b_wdata[b]),
      .be_i      (b_be[b]),
      .amo_i     (b_amo[b]),
      .r_rdata_o (b_rdata[b])
    );
  end

endmodule

`default_nettype wire

//--- source/tcdm_master_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_master_port (
  input  wire logic                                            clk_i,
  input  wire logic                                            arst_n_i,
  input  wire logic                                            req_i,
  input  wire logic [`TCDM_ADDR_WIDTH-1:0]                     add_i,
  input  wire logic                                            we_i,
  input  wire logic [`TCDM_DATA_WIDTH-1:0]                     wdata_i,
  input  wire logic [`TCDM_BE_WIDTH-1:0]                       be_i,
  input  wire logic [`TCDM_ATOP_WIDTH-1:0]                     atop_i,
  output logic                                                 gnt_o,
  output logic                                                 r_valid_o,
  output logic [`TCDM_DATA_WIDTH-1:0]                          r_rdata_o,
  output logic [`TCDM_NB_BANKS-1:0]                            bank_req_o,
  output logic [$clog2(`TCDM_BANK_WORDS)-1:0]                  word_o,
  output logic                                                 bank_we_o,
  output logic [`TCDM_DATA_WIDTH-1:0]                          bank_wdata_o,
  output logic [`TCDM_BE_WIDTH-1:0]                            bank_be_o,
  output tcdm_pkg::amo_op_e                                    amo_o,
  input  wire logic [`TCDM_NB_BANKS-1:0]                       bank_gnt_i,
  input  wire logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_WIDTH-1:0] bank_rdata_i
);

  localparam int unsigned NbBanks      = `TCDM_NB_BANKS;
  localparam int unsigned ByteOffWidth = $clog2(`TCDM_BE_WIDTH);
  localparam int unsigned BankSelWidth = $clog2(`TCDM_NB_BANKS);
  localparam int unsigned WordWidth    = $clog2(`TCDM_BANK_WORDS);

  logic [BankSelWidth-1:0] bank_sel;
  logic [BankSelWidth-1:0] bank_q;
  logic                    rvalid_q;
  logic                    atop_illegal;

  // Low bits pick the bank, the next ones the word, the rest alias
  assign bank_sel = add_i[ByteOffWidth +: BankSelWidth];
  assign word_o   = add_i[ByteOffWidth+BankSelWidth +: WordWidth];

  assign bank_req_o   = req_i ? (NbBanks'(1) << bank_sel) : '0;
  assign bank_wdata_o = wdata_i;
  assign bank_be_o    = be_i;
  // An atomic never counts as a plain write
  assign bank_we_o    = we_i & ~atop_i[5];

  // Map the funct5 code onto the bank operation
  always_comb begin
    amo_o        = tcdm_pkg::AMO_NONE;
    atop_illegal = 1'b0;
    if (atop_i[5]) begin
      case (atop_i[4:0])
        tcdm_pkg::ATOP_ADD:  amo_o = tcdm_pkg::AMO_ADD;
        tcdm_pkg::ATOP_SWAP: amo_o = tcdm_pkg::AMO_SWAP;
        tcdm_pkg::ATOP_XOR:  amo_o = tcdm_pkg::AMO_XOR;
        tcdm_pkg::ATOP_OR:   amo_o = tcdm_pkg::AMO_OR;
        tcdm_pkg::ATOP_AND:  amo_o = tcdm_pkg::AMO_AND;
        tcdm_pkg::ATOP_MIN:  amo_o = tcdm_pkg::AMO_MIN;
        tcdm_pkg::ATOP_MAX:  amo_o = tcdm_pkg::AMO_MAX;
        tcdm_pkg::ATOP_MINU: amo_o = tcdm_pkg::AMO_MINU;
        tcdm_pkg::ATOP_MAXU: amo_o = tcdm_pkg::AMO_MAXU;
        // LR, SC and malformed codes fall through to a plain read
        default:             atop_illegal = 1'b1;
      endcase
    end
  end

  // Only the addressed bank can grant us
  assign gnt_o = |(bank_gnt_i & bank_req_o);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      bank_q   <= '0;
    end else begin
      rvalid_q <= gnt_o;
      if (gnt_o) begin
        bank_q <= bank_sel;
      end
    end
  end

  // Fixed latency of one, the bank's data register is already loaded
  assign r_valid_o = rvalid_q;
  assign r_rdata_o = bank_rdata_i[bank_q];

  illegal_atop_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_i && atop_i[5] |-> !atop_illegal
  ) else $error("unsupported or illegal atomic code %h", atop_i);

  // A waiting master must keep its request unchanged until granted
  req_hold_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_i && !gnt_o |=> req_i && $stable({add_i, we_i, wdata_i, be_i, atop_i})
  ) else $error("request dropped or changed before grant");

endmodule

`default_nettype wire

//--- source/tcdm_pkg.sv
`default_nettype none

package tcdm_pkg;

  // RISC-V AMO funct5 codes as carried in atop[4:0]
  typedef enum logic [4:0] {
    ATOP_ADD  = 5'b00000,
    ATOP_SWAP = 5'b00001,
    ATOP_LR   = 5'b00010,
    ATOP_SC   = 5'b00011,
    ATOP_XOR  = 5'b00100,
    ATOP_OR   = 5'b01000,
    ATOP_AND  = 5'b01100,
    ATOP_MIN  = 5'b10000,
    ATOP_MAX  = 5'b10100,
    ATOP_MINU = 5'b11000,
    ATOP_MAXU = 5'b11100
  } atop_e;

  // Operation carried out by a bank on its old word
  typedef enum logic [3:0] {
    AMO_NONE = 4'h0,
    AMO_SWAP = 4'h1,
    AMO_ADD  = 4'h2,
    AMO_AND  = 4'h3,
    AMO_OR   = 4'h4,
    AMO_XOR  = 4'h5,
    AMO_MAX  = 4'h6,
    AMO_MAXU = 4'h7,
    AMO_MIN  = 4'h8,
    AMO_MINU = 4'h9
  } amo_op_e;

endpackage

`default_nettype wire

//--- tcdm_interconnect.f
+incdir+source
source/tcdm_pkg.sv
source/tcdm_master_port.sv
source/tcdm_bank_arbiter.sv
source/tcdm_amo_bank.sv
source/tcdm_interconnect.sv
tests/tb_clk_gen.sv
tests/tb_tcdm_interconnect.sv

//--- tests/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned ClkPeriod   = 20,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_o = ~clk_o;
    end
  end

  // Release lands on a falling edge, clear of the sampling edge
  initial begin
    arst_n_o = 1'b0;
    #(ClkPeriod * ResetCycles);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/tb_tcdm_interconnect.sv
`timescale 1ns/100ps
`default_nettype none

`include "tcdm_consts.svh"

module tb_tcdm_interconnect;

  localparam int unsigned NbMasters     = `TCDM_NB_MASTERS;
  localparam int unsigned NbBanks       = `TCDM_NB_BANKS;
  localparam int unsigned NbWords       = `TCDM_NB_BANKS * `TCDM_BANK_WORDS;
  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned DriveDelay    = 2;
  localparam int unsigned NbDirected    = 11;
  localparam int unsigned NbRandom      = 40;
  localparam int unsigned NbRows        = NbDirected + NbRandom;
  localparam int unsigned TimeoutCycles = NbRows * 8;

  // One master's request in a table row, with an optional expected response
  typedef struct packed {
    logic                        en;
    logic                        we;
    logic [`TCDM_ADDR_WIDTH-1:0] addr;
    logic [`TCDM_DATA_WIDTH-1:0] wdata;
    logic [`TCDM_BE_WIDTH-1:0]   be;
    logic [`TCDM_ATOP_WIDTH-1:0] atop;
    logic                        ck;
    logic [`TCDM_DATA_WIDTH-1:0] exp_data;
  } op_t;

  logic                                              clk;
  logic                                              arst_n;
  logic [NbMasters-1:0]                              req;
  logic [NbMasters-1:0][`TCDM_ADDR_WIDTH-1:0]        add;
  logic [NbMasters-1:0]                              we;
  logic [NbMasters-1:0][`TCDM_DATA_WIDTH-1:0]        wdata;
  logic [NbMasters-1:0][`TCDM_BE_WIDTH-1:0]          be;
  logic [NbMasters-1:0][`TCDM_ATOP_WIDTH-1:0]        atop;
  logic [NbMasters-1:0]                              gnt;
  logic [NbMasters-1:0]                              r_valid;
  logic [NbMasters-1:0][`TCDM_DATA_WIDTH-1:0]        r_rdata;

  op_t         table_q [NbRows][NbMasters];
  op_t         cur_op [NbMasters];
  logic [31:0] mem_model [NbWords];
  logic        known [NbWords];
  int unsigned rr_ptr [NbBanks];
  logic [31:0] exp_rdata [NbMasters];
  logic [31:0] exp_table [NbMasters];
  logic [NbMasters-1:0] pending;
  logic [NbMasters-1:0] exp_valid;
  logic [NbMasters-1:0] exp_known;
  logic [NbMasters-1:0] exp_ck;
  logic [31:0] seed;
  int unsigned errors;
  int unsigned checks;

  tb_clk_gen #(
    .ClkPeriod   (ClkPeriod),
    .ResetCycles (3)
  ) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  tcdm_interconnect u_tcdm_interconnect (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .req_i     (req),
    .add_i     (add),
    .we_i      (we),
    .wdata_i   (wdata),
    .be_i      (be),
    .atop_i    (atop),
    .gnt_o     (gnt),
    .r_valid_o (r_valid),
    .r_rdata_o (r_rdata)
  );

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Bank in bits 3..2 and word in bits 9..4 give a flat index in bits 9..2
  function automatic int unsigned word_index(input logic [31:0] addr);
    return {24'd0, addr[9:2]};
  endfunction

  function automatic int unsigned bank_of(input logic [31:0] addr);
    return {30'd0, addr[3:2]};
  endfunction

  function automatic op_t write_op(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [3:0] byte_en);
    op_t op;
    op       = '0;
    op.en    = 1'b1;
    op.we    = 1'b1;
    op.addr  = addr;
    op.wdata = data;
    op.be    = byte_en;
    return op;
  endfunction

  function automatic op_t read_op(input logic [31:0] addr, input logic [31:0] expected);
    op_t op;
    op          = '0;
    op.en       = 1'b1;
    op.addr     = addr;
    op.ck       = 1'b1;
    op.exp_data = expected;
    return op;
  endfunction

  // An atomic must ignore the we and be that it carries
  function automatic op_t atomic_op(input tcdm_pkg::atop_e code, input logic [31:0] addr,
                                    input logic [31:0] operand, input logic [31:0] expected);
    op_t op;
    op          = '0;
    op.en       = 1'b1;
    op.we       = 1'b1;
    op.addr     = addr;
    op.wdata    = operand;
    op.atop     = {1'b1, code};
    op.ck       = 1'b1;
    op.exp_data = expected;
    return op;
  endfunction

  function automatic logic [4:0] legal_atop(input int unsigned sel);
    case (sel)
      0:       return tcdm_pkg::ATOP_ADD;
      1:       return tcdm_pkg::ATOP_SWAP;
      2:       return tcdm_pkg::ATOP_XOR;
      3:       return tcdm_pkg::ATOP_OR;
      4:       return tcdm_pkg::ATOP_AND;
      5:       return tcdm_pkg::ATOP_MIN;
      6:       return tcdm_pkg::ATOP_MAX;
      7:       return tcdm_pkg::ATOP_MINU;
      default: return tcdm_pkg::ATOP_MAXU;
    endcase
  endfunction

  // New memory word after an atomic on the old word
  function automatic logic [31:0] amo_expect(input logic [4:0] code, input logic [31:0] old,
                                             input logic [31:0] opnd);
    logic signed [31:0] s_old;
    logic signed [31:0] s_opnd;
    s_old  = old;
    s_opnd = opnd;
    case (code)
      tcdm_pkg::ATOP_ADD:  return old + opnd;
      tcdm_pkg::ATOP_SWAP: return opnd;
      tcdm_pkg::ATOP_XOR:  return old ^ opnd;
      tcdm_pkg::ATOP_OR:   return old | opnd;
      tcdm_pkg::ATOP_AND:  return old & opnd;
      tcdm_pkg::ATOP_MIN:  return (s_old < s_opnd) ? old : opnd;
      tcdm_pkg::ATOP_MAX:  return (s_old > s_opnd) ? old : opnd;
      tcdm_pkg::ATOP_MINU: return (old < opnd) ? old : opnd;
      tcdm_pkg::ATOP_MAXU: return (old > opnd) ? old : opnd;
      default:             return old;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
    end
  endtask

  // Returns the old word and updates the reference memory
  task automatic apply_model(input op_t op, output logic [31:0] old, output logic old_known);
    int unsigned idx;
    logic [31:0] merged;
    idx       = word_index(op.addr);
    old       = mem_model[idx];
    old_known = known[idx];
    merged    = old;
    if (op.atop[5]) begin
      mem_model[idx] = amo_expect(op.atop[4:0], old, op.wdata);
      if (op.atop[4:0] == tcdm_pkg::ATOP_SWAP) begin
        known[idx] = 1'b1;
      end
    end else if (op.we) begin
      for (int unsigned k = 0; k < 4; k++) begin
        if (op.be[k]) begin
          merged[8*k +: 8] = op.wdata[8*k +: 8];
        end
      end
      mem_model[idx] = merged;
      if (op.be == 4'hf) begin
        known[idx] = 1'b1;
      end
    end
  endtask

  task automatic fill_directed();
    // Four banks at once, full then partial writes, then reads
    table_q[0][0] = write_op(32'h010, 32'h1122_3344, 4'hf);
    table_q[0][1] = write_op(32'h014, 32'h5566_7788, 4'hf);
    table_q[0][2] = write_op(32'h018, 32'h99aa_bbcc, 4'hf);
    table_q[0][3] = write_op(32'h01c, 32'hddee_ff00, 4'hf);
    table_q[1][0] = write_op(32'h014, 32'ha5a5_a5a5, 4'h3);
    table_q[1][1] = write_op(32'h018, 32'h5a5a_5a5a, 4'hc);
    table_q[1][2] = write_op(32'h01c, 32'h0012_0000, 4'h4);
    table_q[1][3] = write_op(32'h010, 32'h7f00_0000, 4'h8);
    table_q[2][0] = read_op(32'h010, 32'h7f22_3344);
    table_q[2][1] = read_op(32'h014, 32'h5566_a5a5);
    table_q[2][2] = read_op(32'h018, 32'h5a5a_bbcc);
    table_q[2][3] = read_op(32'h8000_001f, 32'hdd12_ff00);
    // Atomic sequences on word 2 of each bank
    table_q[3][0] = write_op(32'h020, 32'h8000_0005, 4'hf);
    table_q[3][1] = write_op(32'h024, 32'h0000_0007, 4'hf);
    table_q[3][2] = write_op(32'h028, 32'hf0f0_f0f0, 4'hf);
    table_q[3][3] = write_op(32'h02c, 32'h0000_0010, 4'hf);
    table_q[4][0] = atomic_op(tcdm_pkg::ATOP_MIN, 32'h020, 32'h0000_0003, 32'h8000_0005);
    table_q[4][1] = atomic_op(tcdm_pkg::ATOP_ADD, 32'h024, 32'h0000_0009, 32'h0000_0007);
    table_q[4][2] = atomic_op(tcdm_pkg::ATOP_AND, 32'h028, 32'h0ff0_0ff0, 32'hf0f0_f0f0);
    table_q[4][3] = atomic_op(tcdm_pkg::ATOP_MAX, 32'h02c, 32'h8000_0000, 32'h0000_0010);
    table_q[5][0] = atomic_op(tcdm_pkg::ATOP_MINU, 32'h020, 32'h0000_0003, 32'h8000_0005);
    table_q[5][1] = atomic_op(tcdm_pkg::ATOP_SWAP, 32'h024, 32'h1234_5678, 32'h0000_0010);
    table_q[5][2] = read_op(32'h028, 32'h00f0_00f0);
    table_q[5][3] = atomic_op(tcdm_pkg::ATOP_MIN, 32'h02c, 32'h8000_0000, 32'h0000_0010);
    table_q[6][0] = atomic_op(tcdm_pkg::ATOP_MAX, 32'h020, 32'hffff_fff0, 32'h0000_0003);
    table_q[6][1] = atomic_op(tcdm_pkg::ATOP_XOR, 32'h024, 32'h0000_ffff, 32'h1234_5678);
    table_q[6][2] = atomic_op(tcdm_pkg::ATOP_MAXU, 32'h028, 32'h8000_0000, 32'h00f0_00f0);
    table_q[6][3] = read_op(32'h02c, 32'h8000_0000);
    table_q[7][0] = atomic_op(tcdm_pkg::ATOP_MAXU, 32'h020, 32'hffff_fff0, 32'h0000_0003);
    table_q[7][1] = atomic_op(tcdm_pkg::ATOP_OR, 32'h024, 32'h0f00_0000, 32'h1234_a987);
    table_q[7][2] = read_op(32'h028, 32'h8000_0000);
    table_q[8][0] = read_op(32'h020, 32'hffff_fff0);
    table_q[8][1] = read_op(32'h024, 32'h1f34_a987);
    // All four masters contend for bank 2
    table_q[9][0] = write_op(32'h038, 32'haaaa_0000, 4'hf);
    table_q[9][1] = write_op(32'h048, 32'hbbbb_1111, 4'hf);
    table_q[9][2] = write_op(32'h058, 32'hcccc_2222, 4'hf);
    table_q[9][3] = write_op(32'h068, 32'hdddd_3333, 4'hf);
    table_q[10][0] = read_op(32'h068, 32'hdddd_3333);
    table_q[10][1] = read_op(32'h038, 32'haaaa_0000);
    table_q[10][2] = read_op(32'h048, 32'hbbbb_1111);
    table_q[10][3] = read_op(32'h058, 32'hcccc_2222);
  endtask

  task automatic fill_random();
    logic [31:0] ctl;
    logic [31:0] a;
    op_t op;
    for (int unsigned r = NbDirected; r < NbRows; r++) begin
      for (int unsigned m = 0; m < NbMasters; m++) begin
        ctl      = next_random();
        a        = next_random();
        op       = '0;
        op.en    = (ctl[31:30] != 2'b00);
        // Words 0..7 of every bank with random aliasing upper bits
        op.addr  = {a[21:0], 3'b000, a[31:25]};
        op.wdata = next_random();
        case (ctl[29:28])
          2'd0: begin
            op.we = 1'b0;
          end
          2'd1: begin
            op.we = 1'b1;
            op.be = 4'hf;
          end
          2'd2: begin
            op.we = 1'b1;
            op.be = ctl[27:24];
          end
          default: begin
            op.we   = ctl[15];
            op.be   = ctl[27:24];
            op.atop = {1'b1, legal_atop(ctl[23:16] % 9)};
          end
        endcase
        table_q[r][m] = op;
      end
    end
  endtask

  task automatic check_idle();
    check_value("gnt_o", 32'(gnt), 32'h0);
    check_value("r_valid_o", 32'(r_valid), 32'h0);
  endtask

  // Runs at the falling edge when all DUT outputs have settled
  task automatic step_cycle();
    logic [NbMasters-1:0] exp_gnt;
    logic                 found;
    int unsigned          m_idx;
    for (int unsigned m = 0; m < NbMasters; m++) begin
      check_value($sformatf("r_valid_o[%0d]", m), 32'(r_valid[m]), 32'(exp_valid[m]));
      if (exp_valid[m] && exp_known[m]) begin
        check_value($sformatf("r_rdata_o[%0d]", m), r_rdata[m], exp_rdata[m]);
      end
      if (exp_valid[m] && exp_ck[m]) begin
        check_value($sformatf("r_rdata_o[%0d] table", m), r_rdata[m], exp_table[m]);
      end
    end
    // Round-robin prediction per bank
    exp_gnt = '0;
    for (int unsigned b = 0; b < NbBanks; b++) begin
      found = 1'b0;
      for (int unsigned k = 0; k < NbMasters; k++) begin
        m_idx = (rr_ptr[b] + k) % NbMasters;
        if (!found && req[m_idx] && bank_of(add[m_idx]) == b) begin
          found          = 1'b1;
          exp_gnt[m_idx] = 1'b1;
          rr_ptr[b]      = (m_idx + 1) % NbMasters;
        end
      end
    end
    check_value("gnt_o", 32'(gnt), 32'(exp_gnt));
    exp_valid = exp_gnt;
    for (int unsigned m = 0; m < NbMasters; m++) begin
      exp_known[m] = 1'b0;
      exp_ck[m]    = 1'b0;
      if (gnt[m]) begin
        apply_model(cur_op[m], exp_rdata[m], exp_known[m]);
        exp_ck[m]    = cur_op[m].ck;
        exp_table[m] = cur_op[m].exp_data;
        pending[m]   = 1'b0;
      end
    end
  endtask

  // Entered and left just after a rising edge
  task automatic run_row(input int unsigned r);
    for (int unsigned m = 0; m < NbMasters; m++) begin
      cur_op[m] = table_q[r][m];
      if (table_q[r][m].en) begin
        req[m]     = 1'b1;
        add[m]     = table_q[r][m].addr;
        we[m]      = table_q[r][m].we;
        wdata[m]   = table_q[r][m].wdata;
        be[m]      = table_q[r][m].be;
        atop[m]    = table_q[r][m].atop;
        pending[m] = 1'b1;
      end
    end
    while (pending != '0) begin
      @(negedge clk);
      step_cycle();
      @(posedge clk);
      #(DriveDelay);
      for (int unsigned m = 0; m < NbMasters; m++) begin
        if (!pending[m]) begin
          req[m] = 1'b0;
        end
      end
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  initial begin : main
    errors    = 0;
    checks    = 0;
    seed      = 32'h23ac2ee3;
    req       = '0;
    add       = '0;
    we        = '0;
    wdata     = '0;
    be        = '0;
    atop      = '0;
    pending   = '0;
    exp_valid = '0;
    exp_known = '0;
    exp_ck    = '0;
    for (int unsigned b = 0; b < NbBanks; b++) begin
      rr_ptr[b] = 0;
    end
    for (int unsigned i = 0; i < NbWords; i++) begin
      mem_model[i] = '0;
      known[i]     = 1'b0;
    end
    for (int unsigned r = 0; r < NbRows; r++) begin
      for (int unsigned m = 0; m < NbMasters; m++) begin
        table_q[r][m] = '0;
      end
    end
    fill_directed();
    fill_random();
    // Quiet outputs in reset and in the first cycle after it
    repeat (2) begin
      @(negedge clk);
      check_idle();
    end
    wait (arst_n === 1'b1);
    @(negedge clk);
    check_idle();
    @(posedge clk);
    #(DriveDelay);
    for (int unsigned r = 0; r < NbRows; r++) begin
      run_row(r);
    end
    // Last responses and then r_valid_o back low
    repeat (2) begin
      @(negedge clk);
      step_cycle();
    end
    finish_run();
  end

  initial begin : watchdog
    #(TimeoutCycles * ClkPeriod);
    $display("error: timeout, the tests did not finish within %0d cycles", TimeoutCycles);
    errors++;
    finish_run();
  end

endmodule

`default_nettype wire
